//--- hw/alu_rv32i.sv
// Purely combinational; M operation codes give zero here and no zero flag is produced
`timescale 1ns/1ns

module alu_rv32i (
    input  rv_exe_pkg::alu_op_e               op_i,
    input  logic [rv_exe_pkg::DATA_WIDTH-1:0] a_i,
    input  logic [rv_exe_pkg::DATA_WIDTH-1:0] b_i,
    output logic [rv_exe_pkg::DATA_WIDTH-1:0] result_o
);
    import rv_exe_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b_i[4:0];   // RV32 shifts use the low five bits only
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;

    always_comb begin
        case (op_i)
            ADD:     result_o = a_i + b_i;
            SUB:     result_o = a_i - b_i;
            SLL:     result_o = a_i << shamt;
            SLT:     result_o = {{(DATA_WIDTH - 1){1'b0}}, lt_s};
            SLTU:    result_o = {{(DATA_WIDTH - 1){1'b0}}, lt_u};
            XOR:     result_o = a_i ^ b_i;
            SRL:     result_o = a_i >> shamt;
            SRA:     result_o = $unsigned($signed(a_i) >>> shamt);   // Keeps the sign bit
            OR:      result_o = a_i | b_i;
            AND:     result_o = a_i & b_i;
            default: result_o = '0;
        endcase
    end

endmodule

//--- hw/exe_mem_if.sv
// Registered execute-to-memory bundle; valid low means the other fields carry no operation
`timescale 1ns/1ns

interface exe_mem_if;
    import rv_exe_pkg::*;

    logic                      valid;
    logic [REG_ADDR_WIDTH-1:0] regfile_waddr;
    logic                      regfile_wr;
    logic [DATA_WIDTH-1:0]     regfile_rd;     // Writeback value
    logic [DATA_WIDTH-1:0]     data_addr;
    logic                      data_wr;
    logic                      data_rd;
    logic [DATA_WIDTH-1:0]     data_wdata;
    logic [TRANSFER_WIDTH-1:0] write_transfer;
    load_op_e                  load_op;
    logic                      is_load_store;

    modport stage (
        output valid, regfile_waddr, regfile_wr, regfile_rd, data_addr, data_wr,
               data_rd, data_wdata, write_transfer, load_op, is_load_store
    );

    modport sink (
        input valid, regfile_waddr, regfile_wr, regfile_rd, data_addr, data_wr,
              data_rd, data_wdata, write_transfer, load_op, is_load_store
    );

endinterface

//--- hw/exe_stage.sv
// Inputs must stay stable while busy_o is high; an M result waits in the divider under stall
`timescale 1ns/1ns

module exe_stage (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  valid_i,
    input  logic                                  stall_i,
    output logic                                  busy_o,
    input  rv_exe_pkg::alu_op_e                   alu_op_i,
    input  logic                                  use_imm_i,
    input  logic                                  pc_sel_i,
    input  rv_exe_pkg::store_op_e                 store_op_i,
    input  rv_exe_pkg::load_op_e                  load_op_i,
    input  rv_exe_pkg::data_target_e              target_i,
    input  logic [rv_exe_pkg::DATA_WIDTH-1:0]     rs1_i,
    input  logic [rv_exe_pkg::DATA_WIDTH-1:0]     rs2_i,
    input  logic [rv_exe_pkg::DATA_WIDTH-1:0]     imm_i,
    input  logic [rv_exe_pkg::REG_ADDR_WIDTH-1:0] regfile_waddr_i,
    input  logic                                  regfile_wr_i,
    input  logic [rv_exe_pkg::DATA_WIDTH-1:0]     pc4_i,
    input  logic [rv_exe_pkg::DATA_WIDTH-1:0]     brj_pc_i,
    input  logic                                  data_wr_i,
    input  logic                                  data_rd_i,
    input  logic                                  is_load_store_i,
    input  logic [rv_exe_pkg::TRANSFER_WIDTH-1:0] write_transfer_i,
    exe_mem_if.stage                              mem_o
);
    import rv_exe_pkg::*;

    logic [DATA_WIDTH-1:0]     op_b;
    logic [DATA_WIDTH-1:0]     alu_res;
    logic [DATA_WIDTH-1:0]     md_res;
    logic [DATA_WIDTH-1:0]     st_data;
    logic [DATA_WIDTH-1:0]     pc_val;
    logic                      accept;
    logic                      load_i_op;
    logic                      md_start;
    logic                      md_busy;
    logic                      md_done;
    logic                      md_done_q;    // M result finished during a stall
    logic                      m_fin;
    // Held control of the running M operation
    data_target_e              target_q;
    logic [DATA_WIDTH-1:0]     st_data_q;
    logic [DATA_WIDTH-1:0]     pc_val_q;
    logic [REG_ADDR_WIDTH-1:0] waddr_q;
    logic                      regfile_wr_q;
    logic                      data_wr_q;
    logic                      data_rd_q;
    logic [TRANSFER_WIDTH-1:0] transfer_q;
    load_op_e                  load_op_q;
    logic                      is_ls_q;

    function automatic logic [DATA_WIDTH-1:0] wb_select(
        input data_target_e          tgt,
        input logic [DATA_WIDTH-1:0] res,
        input logic [DATA_WIDTH-1:0] wdata,
        input logic [DATA_WIDTH-1:0] pc
    );
        case (tgt)
            TARGET_ALU:   return res;
            TARGET_STORE: return wdata;
            TARGET_ZERO:  return '0;
            default:      return pc;
        endcase
    endfunction

    assign op_b      = use_imm_i ? imm_i : rs2_i;
    assign pc_val    = pc_sel_i ? pc4_i : brj_pc_i;
    assign busy_o    = md_busy || md_done || md_done_q;
    assign accept    = valid_i && !busy_o && !stall_i;
    assign md_start  = accept && alu_op_i[4];
    assign load_i_op = accept && !alu_op_i[4];
    assign m_fin     = md_done || md_done_q;

    always_comb begin
        case (store_op_i)
            STORE_SB: st_data = {{(DATA_WIDTH - 8){1'b0}}, rs2_i[7:0]};
            STORE_SH: st_data = {{(DATA_WIDTH - 16){1'b0}}, rs2_i[15:0]};
            STORE_SW: st_data = rs2_i;
            default:  st_data = '0;
        endcase
    end

    alu_rv32i u_alu (
        .op_i     (alu_op_i),
        .a_i      (rs1_i),
        .b_i      (op_b),
        .result_o (alu_res)
    );

    muldiv_rv32m u_muldiv (
        .clk      (clk),
        .rst_n    (rst_n),
        .start_i  (md_start),
        .funct3_i (alu_op_i[2:0]),
        .a_i      (rs1_i),
        .b_i      (op_b),
        .busy_o   (md_busy),
        .done_o   (md_done),
        .result_o (md_res)
    );

    always_ff @(posedge clk) begin
        if (md_start) begin
            target_q     <= target_i;
            st_data_q    <= st_data;
            pc_val_q     <= pc_val;
            waddr_q      <= regfile_waddr_i;
            regfile_wr_q <= regfile_wr_i;
            data_wr_q    <= data_wr_i;
            data_rd_q    <= data_rd_i;
            transfer_q   <= write_transfer_i;
            load_op_q    <= load_op_i;
            is_ls_q      <= is_load_store_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            md_done_q <= 1'b0;
        end else if (!stall_i) begin
            md_done_q <= 1'b0;           // Result leaves through the pipeline register
        end else if (md_done) begin
            md_done_q <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_o.valid          <= 1'b0;
            mem_o.regfile_waddr  <= '0;
            mem_o.regfile_wr     <= 1'b0;
            mem_o.regfile_rd     <= '0;
            mem_o.data_addr      <= '0;
            mem_o.data_wr        <= 1'b0;
            mem_o.data_rd        <= 1'b0;
            mem_o.data_wdata     <= '0;
            mem_o.write_transfer <= '0;
            mem_o.load_op        <= LB;
            mem_o.is_load_store  <= 1'b0;
        end else if (!stall_i) begin
            mem_o.valid <= load_i_op || m_fin;
            if (load_i_op) begin
                mem_o.regfile_waddr  <= regfile_waddr_i;
                mem_o.regfile_wr     <= regfile_wr_i;
                mem_o.regfile_rd     <= wb_select(target_i, alu_res, st_data, pc_val);
                mem_o.data_addr      <= alu_res;
                mem_o.data_wr        <= data_wr_i;
                mem_o.data_rd        <= data_rd_i;
                mem_o.data_wdata     <= st_data;
                mem_o.write_transfer <= write_transfer_i;
                mem_o.load_op        <= load_op_i;
                mem_o.is_load_store  <= is_load_store_i;
            end else if (m_fin) begin
                mem_o.regfile_waddr  <= waddr_q;
                mem_o.regfile_wr     <= regfile_wr_q;
                mem_o.regfile_rd     <= wb_select(target_q, md_res, st_data_q, pc_val_q);
                mem_o.data_addr      <= md_res;
                mem_o.data_wr        <= data_wr_q;
                mem_o.data_rd        <= data_rd_q;
                mem_o.data_wdata     <= st_data_q;
                mem_o.write_transfer <= transfer_q;
                mem_o.load_op        <= load_op_q;
                mem_o.is_load_store  <= is_ls_q;
            end else begin
                mem_o.regfile_wr    <= 1'b0;   // Bubble, no side effects downstream
                mem_o.data_wr       <= 1'b0;
                mem_o.data_rd       <= 1'b0;
                mem_o.is_load_store <= 1'b0;
            end
        end
    end

endmodule

//--- hw/exe_unit_top.sv
// Plain-port wrapper of the execute stage; m_* outputs are registered, busy_o is combinational
`timescale 1ns/1ns

module exe_unit_top (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  valid_i,
    input  logic                                  stall_i,
    output logic                                  busy_o,
    input  rv_exe_pkg::alu_op_e                   alu_op_i,
    input  logic                                  use_imm_i,
    input  logic                                  pc_sel_i,
    input  rv_exe_pkg::store_op_e                 store_op_i,
    input  rv_exe_pkg::load_op_e                  load_op_i,
    input  rv_exe_pkg::data_target_e              target_i,
    input  logic [rv_exe_pkg::DATA_WIDTH-1:0]     rs1_i,
    input  logic [rv_exe_pkg::DATA_WIDTH-1:0]     rs2_i,
    input  logic [rv_exe_pkg::DATA_WIDTH-1:0]     imm_i,
    input  logic [rv_exe_pkg::REG_ADDR_WIDTH-1:0] regfile_waddr_i,
    input  logic                                  regfile_wr_i,
    input  logic [rv_exe_pkg::DATA_WIDTH-1:0]     pc4_i,
    input  logic [rv_exe_pkg::DATA_WIDTH-1:0]     brj_pc_i,
    input  logic                                  data_wr_i,
    input  logic                                  data_rd_i,
    input  logic                                  is_load_store_i,
    input  logic [rv_exe_pkg::TRANSFER_WIDTH-1:0] write_transfer_i,
    output logic                                  m_valid_o,
    output logic [rv_exe_pkg::REG_ADDR_WIDTH-1:0] m_regfile_waddr_o,
    output logic                                  m_regfile_wr_o,
    output logic [rv_exe_pkg::DATA_WIDTH-1:0]     m_regfile_rd_o,
    output logic [rv_exe_pkg::DATA_WIDTH-1:0]     m_data_addr_o,
    output logic                                  m_data_wr_o,
    output logic                                  m_data_rd_o,
    output logic [rv_exe_pkg::DATA_WIDTH-1:0]     m_data_wdata_o,
    output logic [rv_exe_pkg::TRANSFER_WIDTH-1:0] m_write_transfer_o,
    output rv_exe_pkg::load_op_e                  m_load_op_o,
    output logic                                  m_is_load_store_o
);

    exe_mem_if mem_bus ();

    exe_stage u_exe_stage (
        .clk              (clk),
        .rst_n            (rst_n),
        .valid_i          (valid_i),
        .stall_i          (stall_i),
        .busy_o           (busy_o),
        .alu_op_i         (alu_op_i),
        .use_imm_i        (use_imm_i),
        .pc_sel_i         (pc_sel_i),
        .store_op_i       (store_op_i),
        .load_op_i        (load_op_i),
        .target_i         (target_i),
        .rs1_i            (rs1_i),
        .rs2_i            (rs2_i),
        .imm_i            (imm_i),
        .regfile_waddr_i  (regfile_waddr_i),
        .regfile_wr_i     (regfile_wr_i),
        .pc4_i            (pc4_i),
        .brj_pc_i         (brj_pc_i),
        .data_wr_i        (data_wr_i),
        .data_rd_i        (data_rd_i),
        .is_load_store_i  (is_load_store_i),
        .write_transfer_i (write_transfer_i),
        .mem_o            (mem_bus.stage)
    );

    // Flatten the bundle for the memory stage
    assign m_valid_o          = mem_bus.sink.valid;
    assign m_regfile_waddr_o  = mem_bus.sink.regfile_waddr;
    assign m_regfile_wr_o     = mem_bus.sink.regfile_wr;
    assign m_regfile_rd_o     = mem_bus.sink.regfile_rd;
    assign m_data_addr_o      = mem_bus.sink.data_addr;
    assign m_data_wr_o        = mem_bus.sink.data_wr;
    assign m_data_rd_o        = mem_bus.sink.data_rd;
    assign m_data_wdata_o     = mem_bus.sink.data_wdata;
    assign m_write_transfer_o = mem_bus.sink.write_transfer;
    assign m_load_op_o        = mem_bus.sink.load_op;
    assign m_is_load_store_o  = mem_bus.sink.is_load_store;

endmodule

//--- hw/muldiv_rv32m.sv
// Iterates one bit per cycle with done 33 cycles after start (1 for divide by zero); no abort
`timescale 1ns/1ns

module muldiv_rv32m (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              start_i,
    input  logic [2:0]                        funct3_i,
    input  logic [rv_exe_pkg::DATA_WIDTH-1:0] a_i,
    input  logic [rv_exe_pkg::DATA_WIDTH-1:0] b_i,
    output logic                              busy_o,
    output logic                              done_o,
    output logic [rv_exe_pkg::DATA_WIDTH-1:0] result_o
);
    import rv_exe_pkg::*;

    localparam int CNT_W = $clog2(DATA_WIDTH) + 1;

    logic                      run_q;
    logic [CNT_W-1:0]          cnt_q;
    logic [2:0]                fn_q;
    logic                      neg_q;     // Negate the result at the end
    logic [2*DATA_WIDTH-1:0]   w_q;       // Product or remainder and quotient
    logic [DATA_WIDTH-1:0]     d_q;       // Multiplicand or divisor magnitude
    logic                      is_div;
    logic                      div_zero;
    logic                      a_sgn;
    logic                      b_sgn;
    logic                      a_neg;
    logic                      b_neg;
    logic [DATA_WIDTH-1:0]     a_abs;
    logic [DATA_WIDTH-1:0]     b_abs;
    logic [DATA_WIDTH:0]       mul_sum;
    logic [DATA_WIDTH:0]       div_diff;
    logic [2*DATA_WIDTH-1:0]   prod;
    logic [DATA_WIDTH-1:0]     div_sel;

    // Signed operands for MULH, MULHSU (a only), DIV and REM
    assign is_div   = funct3_i[2];
    assign div_zero = is_div && (b_i == '0);
    assign a_sgn    = (funct3_i == 3'b001) || (funct3_i == 3'b010) || (is_div && !funct3_i[0]);
    assign b_sgn    = (funct3_i == 3'b001) || (is_div && !funct3_i[0]);
    assign a_neg    = a_sgn && a_i[DATA_WIDTH-1];
    assign b_neg    = b_sgn && b_i[DATA_WIDTH-1];
    assign a_abs    = a_neg ? -a_i : a_i;
    assign b_abs    = b_neg ? -b_i : b_i;

    // One shift-add step and one restoring-divide step
    assign mul_sum  = {1'b0, w_q[2*DATA_WIDTH-1:DATA_WIDTH]} + (w_q[0] ? {1'b0, d_q} : '0);
    assign div_diff = w_q[2*DATA_WIDTH-1:DATA_WIDTH-1] - {1'b0, d_q};

    assign busy_o = run_q && (cnt_q != '0);
    assign done_o = run_q && (cnt_q == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q <= 1'b0;
            cnt_q <= '0;
        end else if (start_i) begin
            run_q <= 1'b1;
            cnt_q <= div_zero ? '0 : CNT_W'(DATA_WIDTH);
        end else if (done_o) begin
            run_q <= 1'b0;
        end else if (busy_o) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            fn_q <= funct3_i;
            d_q  <= b_abs;
            if (div_zero) begin
                w_q   <= {a_i, {DATA_WIDTH{1'b1}}};   // Remainder is the dividend and quotient all ones
                neg_q <= 1'b0;
            end else begin
                w_q   <= {{DATA_WIDTH{1'b0}}, a_abs};
                neg_q <= (is_div && funct3_i[1]) ? a_neg : (a_neg ^ b_neg);
            end
        end else if (busy_o) begin
            if (fn_q[2]) begin
                w_q <= div_diff[DATA_WIDTH] ? {w_q[2*DATA_WIDTH-2:0], 1'b0}
                                            : {div_diff[DATA_WIDTH-1:0], w_q[DATA_WIDTH-2:0], 1'b1};
            end else begin
                w_q <= {mul_sum, w_q[DATA_WIDTH-1:1]};
            end
        end
    end

    // Overflow case -2^31 / -1 falls out of the magnitude path unchanged
    assign prod    = neg_q ? -w_q : w_q;
    assign div_sel = fn_q[1] ? w_q[2*DATA_WIDTH-1:DATA_WIDTH] : w_q[DATA_WIDTH-1:0];

    always_comb begin
        if (fn_q[2]) begin
            result_o = neg_q ? -div_sel : div_sel;
        end else if (fn_q[1:0] == 2'b00) begin
            result_o = prod[DATA_WIDTH-1:0];              // MUL low word
        end else begin
            result_o = prod[2*DATA_WIDTH-1:DATA_WIDTH];
        end
    end

endmodule

//--- hw/rv_exe_pkg.sv
// RV32 only; M operations set bit 4 of alu_op_e and carry their funct3 in bits 2:0
package rv_exe_pkg;

    localparam int DATA_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int TRANSFER_WIDTH = 2;   // Memory transfer-size code, passed through

    typedef enum logic [4:0] {
        ADD    = 5'h00,
        SUB    = 5'h01,
        SLL    = 5'h02,
        SLT    = 5'h03,
        SLTU   = 5'h04,
        XOR    = 5'h05,
        SRL    = 5'h06,
        SRA    = 5'h07,
        OR     = 5'h08,
        AND    = 5'h09,
        // M extension, low bits are funct3
        MUL    = 5'h10,
        MULH   = 5'h11,
        MULHSU = 5'h12,
        MULHU  = 5'h13,
        DIV    = 5'h14,
        DIVU   = 5'h15,
        REM    = 5'h16,
        REMU   = 5'h17
    } alu_op_e;

    typedef enum logic [1:0] {
        STORE_NONE = 2'd0,
        STORE_SB   = 2'd1,
        STORE_SH   = 2'd2,
        STORE_SW   = 2'd3
    } store_op_e;

    // Same coding as the load funct3
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } load_op_e;

    typedef enum logic [1:0] {
        TARGET_ALU   = 2'd0,   // ALU or M result
        TARGET_STORE = 2'd1,   // Formatted store data
        TARGET_ZERO  = 2'd2,
        TARGET_PC    = 2'd3    // pc4 or branch/jump target
    } data_target_e;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the execute unit testbench with Verilator, runs it and scans the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f tb.f --top-module tb_exe_unit
./obj_dir/Vtb_exe_unit | tee sim.log

if [ ! -s sim.log ]; then
    echo "simulation produced no log"
    exit 1
fi

if grep -q "Errors found" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi

echo "simulation passed"

//--- sim/tb_exe_unit.sv
// Outputs count as taken at a rising edge with stall_i low; operations wait while busy_o is high
`timescale 1ns/1ns

module tb_exe_unit;
    import rv_exe_pkg::*;

    typedef struct packed {
        logic [REG_ADDR_WIDTH-1:0] waddr;
        logic                      rf_wr;
        logic [DATA_WIDTH-1:0]     rd;
        logic [DATA_WIDTH-1:0]     addr;
        logic                      d_wr;
        logic                      d_rd;
        logic [DATA_WIDTH-1:0]     wdata;
        logic [TRANSFER_WIDTH-1:0] transfer;
        logic [2:0]                load_op;
        logic                      is_ls;
    } expect_t;

    logic                      clk;
    logic                      rst_n;
    logic                      valid_i;
    logic                      stall_i;
    logic                      busy_o;
    alu_op_e                   alu_op_i;
    logic                      use_imm_i;
    logic                      pc_sel_i;
    store_op_e                 store_op_i;
    load_op_e                  load_op_i;
    data_target_e              target_i;
    logic [DATA_WIDTH-1:0]     rs1_i, rs2_i, imm_i, pc4_i, brj_pc_i;
    logic [REG_ADDR_WIDTH-1:0] regfile_waddr_i;
    logic                      regfile_wr_i, data_wr_i, data_rd_i, is_load_store_i;
    logic [TRANSFER_WIDTH-1:0] write_transfer_i;
    logic                      m_valid_o, m_regfile_wr_o, m_data_wr_o, m_data_rd_o;
    logic                      m_is_load_store_o;
    logic [REG_ADDR_WIDTH-1:0] m_regfile_waddr_o;
    logic [DATA_WIDTH-1:0]     m_regfile_rd_o, m_data_addr_o, m_data_wdata_o;
    logic [TRANSFER_WIDTH-1:0] m_write_transfer_o;
    load_op_e                  m_load_op_o;

    expect_t exp_q[$];          // Accepted operations in issue order
    int      errors = 0;
    int      checks = 0;
    int      tests = 0;
    int      stall_pct = 0;     // Chance of stall_i per cycle in percent
    bit      i_accepted = 1'b0; // RV32I operation taken at the coming rising edge

    exe_unit_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] model_alu(input alu_op_e op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [63:0] ext;
        ext = {{32{a[31]}}, a} >> b[4:0];   // Arithmetic shift from the sign-extended word
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            SLL:     return a << b[4:0];
            SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU:    return (a < b) ? 32'd1 : 32'd0;
            XOR:     return a ^ b;
            SRL:     return a >> b[4:0];
            SRA:     return ext[31:0];
            OR:      return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] model_muldiv(input alu_op_e op, input logic [31:0] a,
                                                 input logic [31:0] b);
        logic [63:0]        xa;
        logic [63:0]        xb;
        logic [63:0]        p;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        xa = (op == MULH || op == MULHSU) ? {{32{a[31]}}, a} : {32'd0, a};
        xb = (op == MULH) ? {{32{b[31]}}, b} : {32'd0, b};
        p  = xa * xb;                       // Low 64 bits are exact for every variant
        sa = $signed(a);
        sb = $signed(b);
        case (op)
            MULH, MULHSU, MULHU: return p[63:32];
            DIV, REM: begin
                if (b == '0)
                    return (op == DIV) ? '1 : a;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff)
                    return (op == DIV) ? a : '0;   // Signed overflow rule
                return (op == DIV) ? $unsigned(sa / sb) : $unsigned(sa % sb);
            end
            DIVU, REMU: begin
                if (b == '0)
                    return (op == DIVU) ? '1 : a;
                return (op == DIVU) ? a / b : a % b;
            end
            default: return p[31:0];
        endcase
    endfunction

    function automatic logic [31:0] model_store(input store_op_e sop, input logic [31:0] v);
        case (sop)
            STORE_SB: return {24'd0, v[7:0]};
            STORE_SH: return {16'd0, v[15:0]};
            STORE_SW: return v;
            default:  return '0;
        endcase
    endfunction

    function automatic logic [31:0] pick_operand(input bit corners);
        int sel;
        sel = corners ? int'($urandom_range(5)) : 5;
        case (sel)
            0:       return 32'h0;
            1:       return 32'hffff_ffff;
            2:       return 32'h8000_0000;
            default: return $urandom();
        endcase
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            $display("mismatch at %0t ns: %s expected 0x%08h got 0x%08h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic record_expected();
        expect_t     e;
        logic [31:0] b;
        logic [31:0] res;
        b   = use_imm_i ? imm_i : rs2_i;
        res = alu_op_i[4] ? model_muldiv(alu_op_i, rs1_i, b) : model_alu(alu_op_i, rs1_i, b);
        e.wdata = model_store(store_op_i, rs2_i);
        case (target_i)
            TARGET_ALU:   e.rd = res;
            TARGET_STORE: e.rd = e.wdata;
            TARGET_ZERO:  e.rd = '0;
            default:      e.rd = pc_sel_i ? pc4_i : brj_pc_i;
        endcase
        e.addr     = res;
        e.waddr    = regfile_waddr_i;
        e.rf_wr    = regfile_wr_i;
        e.d_wr     = data_wr_i;
        e.d_rd     = data_rd_i;
        e.transfer = write_transfer_i;
        e.load_op  = load_op_i;
        e.is_ls    = is_load_store_i;
        exp_q.push_back(e);
    endtask

    // Output in the register leaves at the coming edge only if stall_i stays low
    task automatic check_output();
        expect_t e;
        checks++;
        assert (exp_q.size() != 0) else begin
            $display("m_valid_o high at %0t ns with no accepted operation outstanding", $time);
            errors++;
        end
        if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            check_field("m_regfile_waddr_o", 32'(e.waddr), 32'(m_regfile_waddr_o));
            check_field("m_regfile_wr_o", 32'(e.rf_wr), 32'(m_regfile_wr_o));
            check_field("m_regfile_rd_o", e.rd, m_regfile_rd_o);
            check_field("m_data_addr_o", e.addr, m_data_addr_o);
            check_field("m_data_wr_o", 32'(e.d_wr), 32'(m_data_wr_o));
            check_field("m_data_rd_o", 32'(e.d_rd), 32'(m_data_rd_o));
            check_field("m_data_wdata_o", e.wdata, m_data_wdata_o);
            check_field("m_write_transfer_o", 32'(e.transfer), 32'(m_write_transfer_o));
            check_field("m_load_op_o", 32'(e.load_op), 32'(m_load_op_o));
            check_field("m_is_load_store_o", 32'(e.is_ls), 32'(m_is_load_store_o));
        end
    endtask

    task automatic tick();
        logic stall_next;
        @(negedge clk);
        if (i_accepted) begin
            checks++;
            assert (m_valid_o) else begin
                $display("m_valid_o low at %0t ns one cycle after an RV32I operation was taken",
                         $time);
                errors++;
            end
            i_accepted = 1'b0;
        end
        stall_next = ($urandom_range(99) < stall_pct);
        if (m_valid_o && !stall_next)
            check_output();
        stall_i = stall_next;
    endtask

    task automatic gen_fields(input bit m_op, input bit any_target, input int corner);
        int lsel;
        lsel = $urandom_range(4);
        alu_op_i  = m_op ? alu_op_e'(5'h10 | 5'($urandom_range(7)))
                         : alu_op_e'(5'($urandom_range(9)));
        use_imm_i = 1'($urandom_range(1));
        rs1_i     = pick_operand(m_op);
        rs2_i     = pick_operand(m_op);
        imm_i     = pick_operand(m_op);
        if (corner >= 0) begin
            alu_op_i  = alu_op_e'(5'(DIV) + 5'(corner % 4));
            rs1_i     = 32'h8000_0000;
            use_imm_i = 1'b0;
            rs2_i     = (corner < 4) ? '1 : '0;   // Minus one and then zero
        end
        store_op_i       = store_op_e'(2'($urandom_range(3)));
        target_i         = any_target ? data_target_e'(2'($urandom_range(3))) : TARGET_ALU;
        load_op_i        = (lsel < 3) ? load_op_e'(3'(lsel)) : load_op_e'(3'(lsel + 1));
        pc_sel_i         = 1'($urandom_range(1));
        pc4_i            = $urandom();
        brj_pc_i         = $urandom();
        regfile_waddr_i  = 5'($urandom_range(31));
        regfile_wr_i     = 1'($urandom_range(1));
        data_wr_i        = 1'($urandom_range(1));
        data_rd_i        = 1'($urandom_range(1));
        is_load_store_i  = 1'($urandom_range(1));
        write_transfer_i = 2'($urandom_range(3));
    endtask

    task automatic issue_op(input bit m_op, input bit any_target, input int corner);
        int waited;
        waited = 0;
        tick();
        gen_fields(m_op, any_target, corner);
        valid_i = 1'b1;
        while ((busy_o || stall_i) && waited < 200) begin
            tick();                         // Fields are held until accepted
            waited++;
        end
        if (busy_o || stall_i) begin
            $display("timeout at %0t ns: an operation was never accepted", $time);
            errors++;
        end else begin
            record_expected();
            i_accepted = !alu_op_i[4];
        end
    endtask

    task automatic drain(input bit check_busy);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 400) begin
            tick();
            valid_i = 1'b0;
            waited++;
            if (check_busy && !m_valid_o && exp_q.size() != 0) begin
                assert (busy_o) else begin
                    $display("busy_o low at %0t ns while an M operation is running", $time);
                    errors++;
                end
            end
        end
        if (exp_q.size() != 0) begin
            $display("timeout at %0t ns: %0d accepted operations never left the stage",
                     $time, exp_q.size());
            errors++;
            exp_q.delete();
        end
        repeat (3) begin
            tick();                         // Any extra m_valid_o here is a duplicate
            valid_i = 1'b0;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        $display("test %-16s %s, %0d failing checks", name,
                 (errors == errs_before) ? "passed" : "FAILED", errors - errs_before);
    endtask

    initial begin
        int base;
        int i;
        void'($urandom(86));
        rst_n = 1'b0;
        valid_i = 1'b0;
        stall_i = 1'b0;
        gen_fields(1'b0, 1'b0, -1);
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        base = errors;
        tick();
        check_field("m_valid_o", 0, 32'(m_valid_o));
        check_field("m_regfile_wr_o", 0, 32'(m_regfile_wr_o));
        check_field("m_data_wr_o", 0, 32'(m_data_wr_o));
        check_field("m_data_rd_o", 0, 32'(m_data_rd_o));
        check_field("busy_o", 0, 32'(busy_o));
        check_field("m_regfile_rd_o", 0, m_regfile_rd_o);
        check_field("m_data_addr_o", 0, m_data_addr_o);
        check_field("m_data_wdata_o", 0, m_data_wdata_o);
        check_field("m_regfile_waddr_o", 0, 32'(m_regfile_waddr_o));
        check_field("m_write_transfer_o", 0, 32'(m_write_transfer_o));
        check_field("m_load_op_o", 0, 32'(m_load_op_o));
        check_field("m_is_load_store_o", 0, 32'(m_is_load_store_o));
        report_test("reset_state", base);

        base = errors;
        for (i = 0; i < 200; i++)
            issue_op(1'b0, 1'b0, -1);
        drain(1'b0);
        report_test("rv32i_ops", base);

        base = errors;
        for (i = 0; i < 200; i++)
            issue_op(1'b0, 1'b1, -1);
        drain(1'b0);
        report_test("store_and_target", base);

        base = errors;
        for (i = 0; i < 48; i++) begin
            issue_op(1'b1, 1'b1, (i < 8) ? i : -1);   // Overflow and divide by zero first
            drain(1'b1);
        end
        report_test("rv32m_ops", base);

        base = errors;
        stall_pct = 30;
        for (i = 0; i < 150; i++)
            issue_op($urandom_range(4) == 0, 1'b1, -1);
        drain(1'b0);
        stall_pct = 0;
        report_test("back_pressure", base);

        $display("tests %0d, checks %0d, failing checks %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- tb.f
hw/rv_exe_pkg.sv
hw/exe_mem_if.sv
hw/alu_rv32i.sv
hw/muldiv_rv32m.sv
hw/exe_stage.sv
hw/exe_unit_top.sv
sim/tb_exe_unit.sv
